// File: common/agc_io_pkg.sv
/* I/O register select encoding, write port and input word structs,
   telemetry frame phase and position types */
`include "agc_io_settings.svh"

package agc_io_pkg;

  // Register selects, writable ones first
  typedef enum logic [3:0] {
    DSKY_REG_1    = 4'd0,
    DSKY_REG_2    = 4'd1,
    DSKY_REG_3    = 4'd2,
    DSKY_PROG_NUM = 4'd3,
    DSKY_LAMPS    = 4'd4,
    AXI_DVA       = 4'd5,
    AXI_DVATX     = 4'd6,
    AXI_DVB       = 4'd7,
    AXI_DVBTX     = 4'd8,
    // Read-only, driven from outside
    DSKY_VERB     = 4'd9,
    DSKY_NOUN     = 4'd10,
    AXI_G         = 4'd11,
    AXI_RA        = 4'd12,
    AXI_RB        = 4'd13,
    AXI_ATX       = 4'd14
  } io_sel_t;

  // Processor write port
  typedef struct packed {
    logic                en;
    io_sel_t             sel;
    logic [`WORD_W-1:0]  data;
  } io_wr_t;

  // Keyboard and axis input levels
  typedef struct packed {
    logic [`WORD_W-1:0] verb;
    logic [`WORD_W-1:0] noun;
    logic [`WORD_W-1:0] axi_g;
    logic [`WORD_W-1:0] axi_ra;
    logic [`WORD_W-1:0] axi_rb;
    logic [`WORD_W-1:0] axi_atx;
  } dsky_in_t;

  // Telemetry frame sections
  typedef enum logic [2:0] {IDLE, START, DSKY, PROG, LAMPS, AXI} tx_phase_t;

  // Current character within the frame
  typedef struct packed {
    tx_phase_t   phase;
    logic [1:0]  reg_idx;
    logic [3:0]  digit;
  } tx_pos_t;

endpackage

// File: common/agc_io_settings.svh
/* Word widths, output register counts, telemetry frame period
   and the ASCII codes used by the telemetry transmitter */
`ifndef AGC_IO_SETTINGS_SVH
`define AGC_IO_SETTINGS_SVH

// One's-complement data word, sign in bit 14
`define WORD_W 15
// Kept bits of the program number and lamp words
`define PROG_W 5
`define LAMP_W 12

// Writable registers at the bottom of the select space
`define IO_WR_REGS 9
`define DSKY_OUT_REGS 3
`define AXI_OUT_REGS 4

// Idle cycles between frames
`define SEND_PERIOD 1000
`define FRAME_CHARS 57

// ASCII
`define CH_START 8'h3C
`define CH_PLUS 8'h2B
`define CH_MINUS 8'h2D
`define CH_ZERO 8'h30

`endif

// File: hw/io_register_file.sv
/* I/O register file: nine writable output words, readback of the
   input words, processor and telemetry read ports with forwarding */
`include "agc_io_settings.svh"

module io_register_file import agc_io_pkg::*; (
  input  logic                clk,
  input  logic                rst_l,
  input  io_wr_t              wr,
  input  dsky_in_t            dsky_in,
  input  io_sel_t             cpu_sel,
  input  io_sel_t             tx_sel,
  output logic [`WORD_W-1:0]  cpu_data,
  output logic [`WORD_W-1:0]  tx_word
);

  // Full select space, 4-bit select
  localparam int SEL_N = 2 ** $bits(io_sel_t);

  // Writable registers, indexed by select
  logic [`IO_WR_REGS-1:0][`WORD_W-1:0] regs;

  // Everything a read port can see, one entry per select
  logic [SEL_N-1:0][`WORD_W-1:0] rd_table;

  logic                wr_ok;
  logic [`WORD_W-1:0]  wr_word;
  logic                cpu_fwd;
  logic                tx_fwd;

  // Write legality, checked only here
  // Read-only and unused selects drop the write
  assign wr_ok = wr.en && (wr.sel < `IO_WR_REGS);

  // Trim program number and lamps to their kept bits
  always_comb begin
    wr_word = wr.data;
    if (wr.sel == DSKY_PROG_NUM) begin
      wr_word = `WORD_W'(wr.data[`PROG_W-1:0]);
    end
    else if (wr.sel == DSKY_LAMPS) begin
      wr_word = `WORD_W'(wr.data[`LAMP_W-1:0]);
    end
  end

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      regs <= '0;
    end
    else if (wr_ok) begin
      regs[wr.sel] <= wr_word;
    end
  end

  // Readback table
  always_comb begin
    rd_table = '0;
    // Stored words already hold zeros above the kept bits
    rd_table[`IO_WR_REGS-1:0] = regs;
    // Input levels pass straight through
    rd_table[DSKY_VERB] = dsky_in.verb;
    rd_table[DSKY_NOUN] = dsky_in.noun;
    rd_table[AXI_G]     = dsky_in.axi_g;
    rd_table[AXI_RA]    = dsky_in.axi_ra;
    rd_table[AXI_RB]    = dsky_in.axi_rb;
    rd_table[AXI_ATX]   = dsky_in.axi_atx;
    // Select 15 stays zero
  end

  // Same-cycle write hits, per port
  assign cpu_fwd = wr_ok && (cpu_sel == wr.sel);
  assign tx_fwd  = wr_ok && (tx_sel == wr.sel);

  // Processor port, zero latency
  assign cpu_data = cpu_fwd ? wr_word : rd_table[cpu_sel];

  // Telemetry port
  // sees a register update in the cycle it lands
  assign tx_word = tx_fwd ? wr_word : rd_table[tx_sel];

endmodule

// File: hw/io_unit.sv
/* I/O unit top: register file plus telemetry sequencer and formatter */
`include "agc_io_settings.svh"

module io_unit import agc_io_pkg::*; (
  input  logic                clk,
  input  logic                rst_l,
  input  io_wr_t              wr,
  input  dsky_in_t            dsky_in,
  input  io_sel_t             cpu_sel,
  input  logic                tx_busy,
  output logic [`WORD_W-1:0]  cpu_data,
  output logic [7:0]          tx_data,
  output logic                tx_en
);

  // Telemetry side of the register file
  io_sel_t             tx_sel;
  logic [`WORD_W-1:0]  tx_word;
  tx_pos_t             pos;

  io_register_file u_regs (
    .clk      (clk),
    .rst_l    (rst_l),
    .wr       (wr),
    .dsky_in  (dsky_in),
    .cpu_sel  (cpu_sel),
    .tx_sel   (tx_sel),
    .cpu_data (cpu_data),
    .tx_word  (tx_word)
  );

  // Frame timing and register walk
  telemetry_sequencer u_seq (
    .clk     (clk),
    .rst_l   (rst_l),
    .tx_busy (tx_busy),
    .tx_sel  (tx_sel),
    .pos     (pos),
    .tx_en   (tx_en)
  );

  // Word to ASCII
  telemetry_formatter u_fmt (
    .pos     (pos),
    .tx_word (tx_word),
    .tx_data (tx_data)
  );

endmodule

// File: hw/telemetry/telemetry_formatter.sv
/* Telemetry formatter: one ASCII character from the selected
   register word and the frame position */
`include "agc_io_settings.svh"

module telemetry_formatter import agc_io_pkg::*; (
  input  tx_pos_t             pos,
  input  logic [`WORD_W-1:0]  tx_word,
  output logic [7:0]          tx_data
);

  logic [3:0]          oct_shift;
  logic [`WORD_W-1:0]  oct_word;
  logic [2:0]          oct_digit;
  logic [2:0]          prog_digit;
  logic [3:0]          lamp_idx;

  always_comb begin
    // Digit 1 covers bits 13:12, digit 5 covers bits 2:0
    oct_shift = 4'((4'd5 - pos.digit) * 4'd3);
    oct_word  = tx_word >> oct_shift;
    oct_digit = oct_word[2:0];
    // Top digit is two bits, sign sits above it
    if (pos.digit == 4'd1) begin
      oct_digit[2] = 1'b0;
    end

    // Program number, two digits
    if (pos.digit == 4'd0) begin
      prog_digit = 3'(tx_word[`PROG_W-1:3]);
    end
    else begin
      prog_digit = tx_word[2:0];
    end

    // Lamps go out MSB first
    lamp_idx = 4'(`LAMP_W - 1) - pos.digit;

    tx_data = 8'h00;
    case (pos.phase)
      START: tx_data = `CH_START;
      DSKY, AXI: begin
        if (pos.digit == 4'd0) begin
          // Sign character
          tx_data = tx_word[`WORD_W-1] ? `CH_MINUS : `CH_PLUS;
        end
        else begin
          tx_data = `CH_ZERO + {5'd0, oct_digit};
        end
      end
      PROG:    tx_data = `CH_ZERO + {5'd0, prog_digit};
      LAMPS:   tx_data = `CH_ZERO + {7'd0, tx_word[lamp_idx]};
      default: tx_data = 8'h00;
    endcase
  end

endmodule

// File: hw/telemetry/telemetry_sequencer.sv
/* Telemetry sequencer: idle period counter, frame phase FSM,
   register and digit counters, register select for the frame */
`include "agc_io_settings.svh"

module telemetry_sequencer import agc_io_pkg::*; (
  input  logic     clk,
  input  logic     rst_l,
  input  logic     tx_busy,
  output io_sel_t  tx_sel,
  output tx_pos_t  pos,
  output logic     tx_en
);

  localparam int PERIOD_W = $clog2(`SEND_PERIOD);

  tx_pos_t              pos_q;
  tx_pos_t              pos_d;
  logic [PERIOD_W-1:0]  period_q;
  logic [PERIOD_W-1:0]  period_d;
  logic                 last_char;

  // Final digit index of each section
  function automatic logic [3:0] last_digit(input tx_phase_t ph);
    case (ph)
      DSKY, AXI: return 4'd5;
      PROG:      return 4'd1;
      LAMPS:     return 4'(`LAMP_W - 1);
      default:   return 4'd0;
    endcase
  endfunction

  assign last_char = (pos_q.digit == last_digit(pos_q.phase));

  // Next position
  always_comb begin
    pos_d    = pos_q;
    period_d = period_q;
    if (pos_q.phase == IDLE) begin
      // Wait out the period, then open a frame
      if (period_q == PERIOD_W'(`SEND_PERIOD - 1)) begin
        period_d    = '0;
        pos_d.phase = START;
      end
      else begin
        period_d = period_q + 1'b1;
      end
    end
    else if (!tx_busy) begin
      // One character goes out this cycle
      if (!last_char) begin
        pos_d.digit = pos_q.digit + 4'd1;
      end
      else begin
        pos_d.digit = '0;
        case (pos_q.phase)
          START: begin
            pos_d.phase   = DSKY;
            pos_d.reg_idx = '0;
          end
          DSKY: begin
            if (pos_q.reg_idx == 2'(`DSKY_OUT_REGS - 1)) begin
              pos_d.phase   = PROG;
              pos_d.reg_idx = '0;
            end
            else begin
              pos_d.reg_idx = pos_q.reg_idx + 2'd1;
            end
          end
          PROG:  pos_d.phase = LAMPS;
          LAMPS: pos_d.phase = AXI;
          AXI: begin
            // Last axis word closes the frame
            if (pos_q.reg_idx == 2'(`AXI_OUT_REGS - 1)) begin
              pos_d.phase   = IDLE;
              pos_d.reg_idx = '0;
            end
            else begin
              pos_d.reg_idx = pos_q.reg_idx + 2'd1;
            end
          end
          default: pos_d.phase = IDLE;
        endcase
      end
    end
    // Busy holds everything in place
  end

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      pos_q.phase   <= IDLE;
      pos_q.reg_idx <= '0;
      pos_q.digit   <= '0;
      period_q      <= '0;
    end
    else begin
      pos_q    <= pos_d;
      period_q <= period_d;
    end
  end

  // Register feeding the current character
  always_comb begin
    case (pos_q.phase)
      DSKY:    tx_sel = io_sel_t'(4'(DSKY_REG_1) + 4'(pos_q.reg_idx));
      PROG:    tx_sel = DSKY_PROG_NUM;
      LAMPS:   tx_sel = DSKY_LAMPS;
      AXI:     tx_sel = io_sel_t'(4'(AXI_DVA) + 4'(pos_q.reg_idx));
      default: tx_sel = DSKY_REG_1;
    endcase
  end

  assign pos = pos_q;

  // Strobe only when the transmitter can take it
  assign tx_en = (pos_q.phase != IDLE) && !tx_busy;

endmodule

// File: io_unit.f
+incdir+common
common/agc_io_pkg.sv
hw/io_register_file.sv
hw/telemetry/telemetry_sequencer.sv
hw/telemetry/telemetry_formatter.sv
hw/io_unit.sv
testbench/io_unit_tb.sv

// File: testbench/io_unit_tb.sv
/* I/O unit testbench with table-driven register reads, telemetry frame
   prediction from shadow registers, random busy, watchdog and report */
`include "agc_io_settings.svh"

module io_unit_tb import agc_io_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;

  // Stimulus and expected processor read for one cycle
  typedef struct packed {
    logic [2:0]          test_id;
    io_wr_t              wr;
    io_sel_t             rd_sel;
    dsky_in_t            din;
    logic [`WORD_W-1:0]  exp;
  } row_t;

  logic                clk;
  logic                rst_l;
  io_wr_t              wr;
  dsky_in_t            dsky_in;
  io_sel_t             cpu_sel;
  logic                tx_busy;
  logic [`WORD_W-1:0]  cpu_data;
  logic [7:0]          tx_data;
  logic                tx_en;

  row_t                rows[$];
  logic                table_ready;
  // Writable register contents predicted from the writes
  logic [`WORD_W-1:0]  shadow [`IO_WR_REGS];
  logic [7:0]          exp_q[$];
  // Characters and cycle numbers seen on the strobe
  logic [7:0]          cap_q[$];
  int                  strobe_cyc[$];
  int                  cyc;
  logic [15:0]         lfsr;
  logic                rand_busy;
  int                  err_count;
  int                  test_err_base;
  int                  tests_run;
  int                  tests_failed;

  io_unit dut (
    .clk      (clk),
    .rst_l    (rst_l),
    .wr       (wr),
    .dsky_in  (dsky_in),
    .cpu_sel  (cpu_sel),
    .tx_busy  (tx_busy),
    .cpu_data (cpu_data),
    .tx_data  (tx_data),
    .tx_en    (tx_en)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
    end
  end

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  // Bits a register keeps from a write
  function automatic logic [`WORD_W-1:0] mask_word(input io_sel_t sel,
                                                   input logic [`WORD_W-1:0] d);
    logic [`WORD_W-1:0] m;
    m = d;
    if (sel == DSKY_PROG_NUM) begin
      m = d & `WORD_W'((1 << `PROG_W) - 1);
    end
    else if (sel == DSKY_LAMPS) begin
      m = d & `WORD_W'((1 << `LAMP_W) - 1);
    end
    return m;
  endfunction

  task automatic add_row(input logic [2:0] id, input logic en, input io_sel_t sel,
                         input logic [`WORD_W-1:0] data, input io_sel_t rd,
                         input dsky_in_t din, input logic [`WORD_W-1:0] exp);
    row_t r;
    r.test_id = id;
    r.wr.en   = en;
    r.wr.sel  = sel;
    r.wr.data = data;
    r.rd_sel  = rd;
    r.din     = din;
    r.exp     = exp;
    rows.push_back(r);
  endtask

  task automatic build_table();
    dsky_in_t z;
    dsky_in_t pat;
    dsky_in_t alt;
    z           = '0;
    pat.verb    = 15'h0011;
    pat.noun    = 15'h0022;
    pat.axi_g   = 15'h1357;
    pat.axi_ra  = 15'h2468;
    pat.axi_rb  = 15'h7001;
    pat.axi_atx = 15'h4ABC;
    alt         = pat;
    alt.verb    = 15'h6543;
    // Reset values of all writable selects and select 15
    for (int s = 0; s < `IO_WR_REGS; s++) begin
      add_row(3'd1, 1'b0, DSKY_REG_1, '0, io_sel_t'(s), z, '0);
    end
    add_row(3'd1, 1'b0, DSKY_REG_1, '0, io_sel_t'(4'hF), z, '0);
    // Each write read back one row later
    add_row(3'd2, 1'b1, DSKY_REG_1,    15'h5A3C, io_sel_t'(4'hF), z, 15'h0000);
    add_row(3'd2, 1'b1, DSKY_REG_2,    15'h1234, DSKY_REG_1,    z, 15'h5A3C);
    add_row(3'd2, 1'b1, DSKY_REG_3,    15'h7FFF, DSKY_REG_2,    z, 15'h1234);
    add_row(3'd2, 1'b1, DSKY_PROG_NUM, 15'h7ABC, DSKY_REG_3,    z, 15'h7FFF);
    add_row(3'd2, 1'b1, DSKY_LAMPS,    15'h7ABC, DSKY_PROG_NUM, z, 15'h001C);
    add_row(3'd2, 1'b1, AXI_DVA,       15'h4001, DSKY_LAMPS,    z, 15'h0ABC);
    add_row(3'd2, 1'b1, AXI_DVATX,     15'h0F0F, AXI_DVA,       z, 15'h4001);
    add_row(3'd2, 1'b1, AXI_DVB,       15'h3333, AXI_DVATX,     z, 15'h0F0F);
    add_row(3'd2, 1'b1, AXI_DVBTX,     15'h6DB6, AXI_DVB,       z, 15'h3333);
    add_row(3'd2, 1'b0, DSKY_REG_1,    15'h0000, AXI_DVBTX,     z, 15'h6DB6);
    // Read-only selects ignore writes and show the input levels
    add_row(3'd2, 1'b1, DSKY_VERB, 15'h7777, DSKY_VERB, pat, 15'h0011);
    add_row(3'd2, 1'b1, DSKY_NOUN, 15'h7777, DSKY_NOUN, pat, 15'h0022);
    add_row(3'd2, 1'b1, AXI_G,     15'h0000, AXI_G,     pat, 15'h1357);
    add_row(3'd2, 1'b1, AXI_RA,    15'h1111, AXI_RA,    pat, 15'h2468);
    add_row(3'd2, 1'b1, AXI_RB,    15'h5555, AXI_RB,    pat, 15'h7001);
    add_row(3'd2, 1'b1, AXI_ATX,   15'h0001, AXI_ATX,   pat, 15'h4ABC);
    add_row(3'd2, 1'b1, io_sel_t'(4'hF), 15'h7FFF, io_sel_t'(4'hF), pat, 15'h0000);
    add_row(3'd2, 1'b0, DSKY_REG_1, 15'h0000, DSKY_VERB, alt, 15'h6543);
    // Same-cycle write and read get forwarded and masked data
    add_row(3'd3, 1'b1, DSKY_REG_2,    15'h2AAA, DSKY_REG_2,    pat, 15'h2AAA);
    add_row(3'd3, 1'b1, DSKY_PROG_NUM, 15'h7FFF, DSKY_PROG_NUM, pat, 15'h001F);
    add_row(3'd3, 1'b1, DSKY_LAMPS,    15'h5123, DSKY_LAMPS,    pat, 15'h0123);
    add_row(3'd3, 1'b1, AXI_DVB,       15'h0707, AXI_DVB,       pat, 15'h0707);
    // Disabled write leaves the stored word
    add_row(3'd3, 1'b0, DSKY_REG_2,    15'h1111, DSKY_REG_2,    pat, 15'h2AAA);
    add_row(3'd3, 1'b0, DSKY_REG_1,    15'h0000, DSKY_PROG_NUM, pat, 15'h001F);
    add_row(3'd3, 1'b0, DSKY_REG_1,    15'h0000, DSKY_LAMPS,    pat, 15'h0123);
    add_row(3'd3, 1'b0, DSKY_REG_1,    15'h0000, AXI_DVB,       pat, 15'h0707);
  endtask

  task automatic report_test(input int id);
    string name;
    case (id)
      1:       name = "reset values, no strobe";
      2:       name = "register writes and input readback";
      3:       name = "same-cycle forwarding";
      4:       name = "first frame, transmitter idle";
      default: name = "second frame, random busy";
    endcase
    tests_run++;
    if (err_count == test_err_base) begin
      $display("test %0d, %s: ok", id, name);
    end
    else begin
      tests_failed++;
      $display("test %0d, %s: %0d errors", id, name, err_count - test_err_base);
    end
    test_err_base = err_count;
  endtask

  task automatic apply_table();
    row_t r;
    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      if (i > 0 && r.test_id != rows[i-1].test_id) begin
        report_test(rows[i-1].test_id);
      end
      @(negedge clk);
      wr      = r.wr;
      cpu_sel = r.rd_sel;
      dsky_in = r.din;
      // Read port settles well before the rising edge
      #(CLK_PERIOD / 4);
      if (cpu_data !== r.exp) begin
        err_count++;
        $display("FAIL t=%0t: row %0d select %0d reads %h, expected %h",
                 $time, i, r.rd_sel, cpu_data, r.exp);
      end
      if (r.test_id == 3'd1 && tx_en !== 1'b0) begin
        err_count++;
        $display("FAIL t=%0t: tx_en high before the first frame", $time);
      end
      if (r.wr.en && r.wr.sel < `IO_WR_REGS) begin
        shadow[r.wr.sel] = mask_word(r.wr.sel, r.wr.data);
      end
    end
    report_test(rows[rows.size()-1].test_id);
    @(negedge clk);
    wr = '0;
  endtask

  // Sign and five octal digits with a two-bit top digit
  task automatic push_word(input logic [`WORD_W-1:0] w);
    exp_q.push_back(w[`WORD_W-1] ? `CH_MINUS : `CH_PLUS);
    exp_q.push_back(`CH_ZERO + {6'd0, w[13:12]});
    exp_q.push_back(`CH_ZERO + {5'd0, w[11:9]});
    exp_q.push_back(`CH_ZERO + {5'd0, w[8:6]});
    exp_q.push_back(`CH_ZERO + {5'd0, w[5:3]});
    exp_q.push_back(`CH_ZERO + {5'd0, w[2:0]});
  endtask

  task automatic predict_frame();
    logic [`WORD_W-1:0] prog;
    logic [`WORD_W-1:0] lamps;
    prog  = shadow[DSKY_PROG_NUM];
    lamps = shadow[DSKY_LAMPS];
    exp_q.delete();
    exp_q.push_back(`CH_START);
    for (int k = 0; k < `DSKY_OUT_REGS; k++) begin
      push_word(shadow[DSKY_REG_1 + k]);
    end
    exp_q.push_back(`CH_ZERO + {6'd0, prog[4:3]});
    exp_q.push_back(`CH_ZERO + {5'd0, prog[2:0]});
    // Lamps MSB first
    for (int b = `LAMP_W - 1; b >= 0; b--) begin
      exp_q.push_back(`CH_ZERO + {7'd0, lamps[b]});
    end
    for (int k = 0; k < `AXI_OUT_REGS; k++) begin
      push_word(shadow[AXI_DVA + k]);
    end
  endtask

  task automatic check_frame(input int base);
    for (int k = 0; k < `FRAME_CHARS; k++) begin
      if (cap_q[base + k] !== exp_q[k]) begin
        err_count++;
        $display("FAIL t=%0t: frame character %0d is %h, expected %h",
                 $time, k, cap_q[base + k], exp_q[k]);
      end
    end
  endtask

  // Strobe monitor sampling mid low phase
  initial begin
    cyc = 0;
    forever begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      if (rst_l) begin
        if (tx_en === 1'b1) begin
          if (tx_busy !== 1'b0) begin
            err_count++;
            $display("FAIL t=%0t: tx_en high while tx_busy high", $time);
          end
          cap_q.push_back(tx_data);
          strobe_cyc.push_back(cyc);
        end
        cyc++;
      end
    end
  end

  // Busy level takes one LFSR bit per cycle once enabled
  initial begin
    lfsr = 16'd50861;
    forever begin
      @(negedge clk);
      if (rand_busy) begin
        tx_busy = lfsr[0];
        lfsr    = lfsr_next(lfsr);
      end
      else begin
        tx_busy = 1'b0;
      end
    end
  end

  initial begin
    int limit;
    wait (table_ready === 1'b1);
    // Idle periods and frames with room for busy cycles in the second
    limit = RESET_CYCLES + rows.size() + 3 * `SEND_PERIOD + 40 * `FRAME_CHARS;
    #(limit * CLK_PERIOD);
    $display("Timeout: the telemetry frames did not complete within %0d cycles", limit);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    rst_l         = 1'b0;
    wr            = '0;
    dsky_in       = '0;
    cpu_sel       = DSKY_REG_1;
    tx_busy       = 1'b0;
    rand_busy     = 1'b0;
    table_ready   = 1'b0;
    err_count     = 0;
    test_err_base = 0;
    tests_run     = 0;
    tests_failed  = 0;
    for (int k = 0; k < `IO_WR_REGS; k++) begin
      shadow[k] = '0;
    end
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_l = 1'b1;

    // Tests 1 to 3
    apply_table();

    // First frame after one idle period on consecutive cycles
    predict_frame();
    while (cap_q.size() < `FRAME_CHARS) @(negedge clk);
    if (strobe_cyc[0] != `SEND_PERIOD) begin
      err_count++;
      $display("FAIL t=%0t: first strobe in cycle %0d, expected %0d",
               $time, strobe_cyc[0], `SEND_PERIOD);
    end
    if (strobe_cyc[`FRAME_CHARS-1] - strobe_cyc[0] != `FRAME_CHARS - 1) begin
      err_count++;
      $display("FAIL t=%0t: first frame spans %0d cycles, expected %0d", $time,
               strobe_cyc[`FRAME_CHARS-1] - strobe_cyc[0] + 1, `FRAME_CHARS);
    end
    check_frame(0);
    report_test(4);

    // New register value between frames before random busy starts
    @(negedge clk);
    wr.en   = 1'b1;
    wr.sel  = DSKY_REG_1;
    wr.data = 15'h0A5F;
    #(CLK_PERIOD / 4);
    rand_busy          = 1'b1;
    shadow[DSKY_REG_1] = mask_word(DSKY_REG_1, 15'h0A5F);
    @(negedge clk);
    wr = '0;
    predict_frame();
    while (cap_q.size() < 2 * `FRAME_CHARS) @(negedge clk);
    check_frame(`FRAME_CHARS);
    if (strobe_cyc[2*`FRAME_CHARS-1] - strobe_cyc[`FRAME_CHARS] == `FRAME_CHARS - 1) begin
      err_count++;
      $display("The busy level never held the second frame");
    end
    report_test(5);

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end
    else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
